/* Bender.yml */
package:
  name: mul_issue

sources:
  - src/rv32m_pkg.sv
  - src/ooo_pkg.sv
  - src/rs_ctrl.sv
  - src/rs_entries.sv
  - src/phys_reg_file.sv
  - src/mul_unit.sv
  - src/mul_issue_top.sv
  - target: test
    include_dirs:
      - testbench
    files:
      - testbench/tb_mul_issue.sv

/* flist.f */
+incdir+testbench
src/rv32m_pkg.sv
src/ooo_pkg.sv
src/rs_ctrl.sv
src/rs_entries.sv
src/phys_reg_file.sv
src/mul_unit.sv
src/mul_issue_top.sv
testbench/tb_mul_issue.sv

/* src/mul_issue_top.sv */
`default_nettype none

module mul_issue_top (
    input  logic                           clk,
    input  logic                           rst,
    input  logic                           disp_valid,
    input  logic [ooo_pkg::TAG_W-1:0]      disp_dst_tag,
    input  logic [ooo_pkg::TAG_W-1:0]      disp_src1_tag,
    input  logic [ooo_pkg::TAG_W-1:0]      disp_src2_tag,
    input  logic                           disp_src1_rdy,
    input  logic                           disp_src2_rdy,
    input  logic [rv32m_pkg::FUNCT3_W-1:0] disp_funct3,
    input  logic                           ext_cdb_valid,
    input  logic [ooo_pkg::TAG_W-1:0]      ext_cdb_tag,
    input  logic [rv32m_pkg::XLEN-1:0]     ext_cdb_data,
    output logic                           table_full,
    output logic                           cdb_valid,
    output logic [ooo_pkg::TAG_W-1:0]      cdb_tag,
    output logic [rv32m_pkg::XLEN-1:0]     cdb_data
);

    logic [ooo_pkg::RS_DEPTH-1:0]   alloc_we;
    logic [ooo_pkg::RS_DEPTH-1:0]   entry_ready;
    logic                           issue_valid;
    logic [ooo_pkg::RS_IDX_W-1:0]   issue_idx;
    logic [ooo_pkg::TAG_W-1:0]      sel_dst_tag;
    logic [ooo_pkg::TAG_W-1:0]      sel_src1_tag;
    logic [ooo_pkg::TAG_W-1:0]      sel_src2_tag;
    logic [rv32m_pkg::FUNCT3_W-1:0] sel_funct3;
    logic [rv32m_pkg::XLEN-1:0]     opnd_a;
    logic [rv32m_pkg::XLEN-1:0]     opnd_b;

    rs_ctrl i_rs_ctrl (
        .clk         (clk),
        .rst         (rst),
        .disp_valid  (disp_valid),
        .entry_ready (entry_ready),
        .alloc_we    (alloc_we),
        .issue_valid (issue_valid),
        .issue_idx   (issue_idx),
        .table_full  (table_full)
    );

    // Wakeup sees the external bus and our own broadcast
    rs_entries i_rs_entries (
        .clk           (clk),
        .alloc_we      (alloc_we),
        .disp_dst_tag  (disp_dst_tag),
        .disp_src1_tag (disp_src1_tag),
        .disp_src2_tag (disp_src2_tag),
        .disp_src1_rdy (disp_src1_rdy),
        .disp_src2_rdy (disp_src2_rdy),
        .disp_funct3   (disp_funct3),
        .ext_cdb_valid (ext_cdb_valid),
        .ext_cdb_tag   (ext_cdb_tag),
        .cdb_valid     (cdb_valid),
        .cdb_tag       (cdb_tag),
        .issue_idx     (issue_idx),
        .entry_ready   (entry_ready),
        .sel_dst_tag   (sel_dst_tag),
        .sel_src1_tag  (sel_src1_tag),
        .sel_src2_tag  (sel_src2_tag),
        .sel_funct3    (sel_funct3)
    );

    phys_reg_file i_prf (
        .clk      (clk),
        .rst      (rst),
        .wa_valid (ext_cdb_valid),
        .wa_tag   (ext_cdb_tag),
        .wa_data  (ext_cdb_data),
        .wb_valid (cdb_valid),
        .wb_tag   (cdb_tag),
        .wb_data  (cdb_data),
        .ra_tag   (sel_src1_tag),
        .rb_tag   (sel_src2_tag),
        .ra_data  (opnd_a),
        .rb_data  (opnd_b)
    );

    mul_unit i_mul_unit (
        .clk        (clk),
        .rst        (rst),
        .in_valid   (issue_valid),
        .in_funct3  (sel_funct3),
        .in_dst_tag (sel_dst_tag),
        .in_a       (opnd_a),
        .in_b       (opnd_b),
        .out_valid  (cdb_valid),
        .out_tag    (cdb_tag),
        .out_data   (cdb_data)
    );

endmodule

`default_nettype wire

/* src/mul_unit.sv */
`default_nettype none

module mul_unit (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          in_valid,
    input  logic [rv32m_pkg::FUNCT3_W-1:0] in_funct3,
    input  logic [ooo_pkg::TAG_W-1:0]     in_dst_tag,
    input  logic [rv32m_pkg::XLEN-1:0]    in_a,
    input  logic [rv32m_pkg::XLEN-1:0]    in_b,
    output logic                          out_valid,
    output logic [ooo_pkg::TAG_W-1:0]     out_tag,
    output logic [rv32m_pkg::XLEN-1:0]    out_data
);

    logic                           a_signed;
    logic                           b_signed;

    // Stage 1, extended operands
    logic                           s1_valid;
    logic [ooo_pkg::TAG_W-1:0]      s1_tag;
    logic [rv32m_pkg::FUNCT3_W-1:0] s1_funct3;
    logic signed [rv32m_pkg::XLEN:0] s1_a;
    logic signed [rv32m_pkg::XLEN:0] s1_b;

    // Stage 2, full product
    logic                           s2_valid;
    logic [ooo_pkg::TAG_W-1:0]      s2_tag;
    logic [rv32m_pkg::FUNCT3_W-1:0] s2_funct3;
    logic signed [2*rv32m_pkg::XLEN-1:0] s2_prod;

    // Operand signedness per encoding
    always_comb begin
        case (in_funct3)
            rv32m_pkg::F3_MUL,
            rv32m_pkg::F3_MULH: begin
                a_signed = 1'b1;
                b_signed = 1'b1;
            end
            rv32m_pkg::F3_MULHSU: begin
                a_signed = 1'b1;
                b_signed = 1'b0;
            end
            rv32m_pkg::F3_MULHU: begin
                a_signed = 1'b0;
                b_signed = 1'b0;
            end
            default: begin
                a_signed = 1'b0;
                b_signed = 1'b0;
            end
        endcase
    end

    // Valid bits flow through reset, payload does not
    always_ff @(posedge clk) begin
        if (rst) begin
            s1_valid  <= 1'b0;
            s2_valid  <= 1'b0;
            out_valid <= 1'b0;
        end else begin
            s1_valid  <= in_valid;
            s2_valid  <= s1_valid;
            out_valid <= s2_valid;
        end
    end

    always_ff @(posedge clk) begin
        s1_tag    <= in_dst_tag;
        s1_funct3 <= in_funct3;
        s1_a      <= {a_signed & in_a[rv32m_pkg::XLEN-1], in_a};
        s1_b      <= {b_signed & in_b[rv32m_pkg::XLEN-1], in_b};

        s2_tag    <= s1_tag;
        s2_funct3 <= s1_funct3;
        // 33x33 signed, low 64 bits cover every variant
        s2_prod   <= s1_a * s1_b;

        out_tag   <= s2_tag;
        if (s2_funct3 == rv32m_pkg::F3_MUL) begin
            out_data <= s2_prod[rv32m_pkg::XLEN-1:0];
        end else begin
            out_data <= s2_prod[2*rv32m_pkg::XLEN-1:rv32m_pkg::XLEN];
        end
    end

endmodule

`default_nettype wire

/* src/ooo_pkg.sv */
`default_nettype none

package ooo_pkg;

    // Physical register file size
    localparam int PRF_DEPTH = 64;

    // Tag that names one physical register
    localparam int TAG_W = $clog2(PRF_DEPTH);

    // Multiply reservation station slots
    localparam int RS_DEPTH = 8;

    // Index of one station slot
    localparam int RS_IDX_W = $clog2(RS_DEPTH);

    // Cycles from issue to result broadcast
    localparam int MUL_STAGES = 3;

endpackage

`default_nettype wire

/* src/phys_reg_file.sv */
`default_nettype none

module phys_reg_file (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          wa_valid,
    input  logic [ooo_pkg::TAG_W-1:0]     wa_tag,
    input  logic [rv32m_pkg::XLEN-1:0]    wa_data,
    input  logic                          wb_valid,
    input  logic [ooo_pkg::TAG_W-1:0]     wb_tag,
    input  logic [rv32m_pkg::XLEN-1:0]    wb_data,
    input  logic [ooo_pkg::TAG_W-1:0]     ra_tag,
    input  logic [ooo_pkg::TAG_W-1:0]     rb_tag,
    output logic [rv32m_pkg::XLEN-1:0]    ra_data,
    output logic [rv32m_pkg::XLEN-1:0]    rb_data
);

    logic [rv32m_pkg::XLEN-1:0] regs [ooo_pkg::PRF_DEPTH];

    // The two buses never target the same tag in one cycle
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < ooo_pkg::PRF_DEPTH; i++) begin
                regs[i] <= '0;
            end
        end else begin
            if (wa_valid) begin
                regs[wa_tag] <= wa_data;
            end
            if (wb_valid) begin
                regs[wb_tag] <= wb_data;
            end
        end
    end

    // Asynchronous reads, no bypass needed since wakeup trails the write
    always_comb begin
        ra_data = regs[ra_tag];
        rb_data = regs[rb_tag];
    end

endmodule

`default_nettype wire

/* src/rs_ctrl.sv */
`default_nettype none

module rs_ctrl (
    input  logic                             clk,
    input  logic                             rst,
    input  logic                             disp_valid,
    input  logic [ooo_pkg::RS_DEPTH-1:0]     entry_ready,
    output logic [ooo_pkg::RS_DEPTH-1:0]     alloc_we,
    output logic                             issue_valid,
    output logic [ooo_pkg::RS_IDX_W-1:0]     issue_idx,
    output logic                             table_full
);

    logic [ooo_pkg::RS_DEPTH-1:0] busy;
    logic [ooo_pkg::RS_DEPTH-1:0] issue_cand;
    logic [ooo_pkg::RS_DEPTH-1:0] issue_oh;
    logic [ooo_pkg::RS_DEPTH-1:0] free_slots;
    logic [ooo_pkg::RS_IDX_W-1:0] alloc_idx;
    logic                         alloc_any;
    logic [ooo_pkg::RS_IDX_W:0]   busy_cnt;

    // Issue select, lowest busy slot with both sources ready
    always_comb begin
        issue_cand  = busy & entry_ready;
        issue_valid = |issue_cand;
        issue_idx   = '0;
        for (int i = ooo_pkg::RS_DEPTH - 1; i >= 0; i--) begin
            if (issue_cand[i]) begin
                issue_idx = ooo_pkg::RS_IDX_W'(i);
            end
        end
        issue_oh = '0;
        if (issue_valid) begin
            issue_oh[issue_idx] = 1'b1;
        end
    end

    // Allocation, the slot leaving this cycle counts as free
    always_comb begin
        free_slots = ~busy | issue_oh;
        alloc_any  = |free_slots;
        alloc_idx  = '0;
        for (int i = ooo_pkg::RS_DEPTH - 1; i >= 0; i--) begin
            if (free_slots[i]) begin
                alloc_idx = ooo_pkg::RS_IDX_W'(i);
            end
        end
        alloc_we = '0;
        if (disp_valid && alloc_any) begin
            alloc_we[alloc_idx] = 1'b1;
        end
    end

    // Occupancy
    always_comb begin
        busy_cnt = '0;
        for (int i = 0; i < ooo_pkg::RS_DEPTH; i++) begin
            busy_cnt = busy_cnt + (ooo_pkg::RS_IDX_W + 1)'(busy[i]);
        end
        table_full = (busy_cnt == (ooo_pkg::RS_IDX_W + 1)'(ooo_pkg::RS_DEPTH));
    end

    // Set wins over clear when an issuing slot is refilled
    always_ff @(posedge clk) begin
        if (rst) begin
            busy <= '0;
        end else begin
            busy <= (busy & ~issue_oh) | alloc_we;
        end
    end

endmodule

`default_nettype wire

/* src/rs_entries.sv */
`default_nettype none

module rs_entries (
    input  logic                              clk,
    input  logic [ooo_pkg::RS_DEPTH-1:0]      alloc_we,
    input  logic [ooo_pkg::TAG_W-1:0]         disp_dst_tag,
    input  logic [ooo_pkg::TAG_W-1:0]         disp_src1_tag,
    input  logic [ooo_pkg::TAG_W-1:0]         disp_src2_tag,
    input  logic                              disp_src1_rdy,
    input  logic                              disp_src2_rdy,
    input  logic [rv32m_pkg::FUNCT3_W-1:0]    disp_funct3,
    input  logic                              ext_cdb_valid,
    input  logic [ooo_pkg::TAG_W-1:0]         ext_cdb_tag,
    input  logic                              cdb_valid,
    input  logic [ooo_pkg::TAG_W-1:0]         cdb_tag,
    input  logic [ooo_pkg::RS_IDX_W-1:0]      issue_idx,
    output logic [ooo_pkg::RS_DEPTH-1:0]      entry_ready,
    output logic [ooo_pkg::TAG_W-1:0]         sel_dst_tag,
    output logic [ooo_pkg::TAG_W-1:0]         sel_src1_tag,
    output logic [ooo_pkg::TAG_W-1:0]         sel_src2_tag,
    output logic [rv32m_pkg::FUNCT3_W-1:0]    sel_funct3
);

    // Slot storage
    logic [ooo_pkg::TAG_W-1:0]      dst_tag_q  [ooo_pkg::RS_DEPTH];
    logic [ooo_pkg::TAG_W-1:0]      src1_tag_q [ooo_pkg::RS_DEPTH];
    logic [ooo_pkg::TAG_W-1:0]      src2_tag_q [ooo_pkg::RS_DEPTH];
    logic [rv32m_pkg::FUNCT3_W-1:0] funct3_q   [ooo_pkg::RS_DEPTH];
    logic [ooo_pkg::RS_DEPTH-1:0]   src1_rdy_q;
    logic [ooo_pkg::RS_DEPTH-1:0]   src2_rdy_q;

    // A tag is produced when either bus carries it this cycle
    function automatic logic bus_hit(input logic [ooo_pkg::TAG_W-1:0] tag);
        logic ext_hit;
        logic own_hit;
        ext_hit = ext_cdb_valid && (ext_cdb_tag == tag);
        own_hit = cdb_valid && (cdb_tag == tag);
        return ext_hit || own_hit;
    endfunction

    always_ff @(posedge clk) begin
        for (int i = 0; i < ooo_pkg::RS_DEPTH; i++) begin
            if (alloc_we[i]) begin
                dst_tag_q[i]  <= disp_dst_tag;
                src1_tag_q[i] <= disp_src1_tag;
                src2_tag_q[i] <= disp_src2_tag;
                funct3_q[i]   <= disp_funct3;
                // Catch a broadcast that lands in the dispatch cycle
                src1_rdy_q[i] <= disp_src1_rdy | bus_hit(disp_src1_tag);
                src2_rdy_q[i] <= disp_src2_rdy | bus_hit(disp_src2_tag);
            end else begin
                src1_rdy_q[i] <= src1_rdy_q[i] | bus_hit(src1_tag_q[i]);
                src2_rdy_q[i] <= src2_rdy_q[i] | bus_hit(src2_tag_q[i]);
            end
        end
    end

    // Operand readiness only, the busy bit lives in rs_ctrl
    always_comb begin
        for (int i = 0; i < ooo_pkg::RS_DEPTH; i++) begin
            entry_ready[i] = src1_rdy_q[i] & src2_rdy_q[i];
        end
    end

    // Issue read mux
    always_comb begin
        sel_dst_tag  = dst_tag_q[issue_idx];
        sel_src1_tag = src1_tag_q[issue_idx];
        sel_src2_tag = src2_tag_q[issue_idx];
        sel_funct3   = funct3_q[issue_idx];
    end

endmodule

`default_nettype wire

/* src/rv32m_pkg.sv */
`default_nettype none

package rv32m_pkg;

    // Architectural data word
    localparam int XLEN = 32;

    // Width of the funct3 field in an OP-type instruction
    localparam int FUNCT3_W = 3;

    // Multiply group encodings (funct7 = 0000001)

    // Low half of the product, signedness does not matter
    localparam logic [FUNCT3_W-1:0] F3_MUL = 3'd0;

    // High half, both operands signed
    localparam logic [FUNCT3_W-1:0] F3_MULH = 3'd1;

    // High half, rs1 signed and rs2 unsigned
    localparam logic [FUNCT3_W-1:0] F3_MULHSU = 3'd2;

    // High half, both operands unsigned
    localparam logic [FUNCT3_W-1:0] F3_MULHU = 3'd3;

endpackage

`default_nettype wire

/* testbench/tb_mul_checks.svh */
`ifndef TB_MUL_CHECKS_SVH
`define TB_MUL_CHECKS_SVH

// Galois LFSR, x^16 + x^14 + x^13 + x^11 + 1
localparam logic [15:0] LFSR_SEED = 16'd12710;
localparam logic [15:0] LFSR_TAPS = 16'hB400;

logic [15:0] lfsr_state = LFSR_SEED;

function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    if (s[0]) begin
        return (s >> 1) ^ LFSR_TAPS;
    end
    return s >> 1;
endfunction

// One LFSR step per bit taken, newest bit lands in bit 0
function automatic logic [31:0] take_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
        lfsr_state = lfsr_next(lfsr_state);
        v = {v[30:0], lfsr_state[0]};
    end
    return v;
endfunction

task automatic check_data(input string name, input logic [rv32m_pkg::XLEN-1:0] got,
                          input logic [rv32m_pkg::XLEN-1:0] exp);
    if (got !== exp) begin
        fail_stop($sformatf("CHECK FAILED %s got 0x%h expected 0x%h", name, got, exp));
    end
endtask

task automatic check_tag(input string name, input logic [ooo_pkg::TAG_W-1:0] got,
                         input logic [ooo_pkg::TAG_W-1:0] exp);
    if (got !== exp) begin
        fail_stop($sformatf("CHECK FAILED %s got 0x%h expected 0x%h", name, got, exp));
    end
endtask

task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
        fail_stop($sformatf("CHECK FAILED %s got 0x%h expected 0x%h", name, got, exp));
    end
endtask

`endif

/* testbench/tb_mul_issue.sv */
`default_nettype none

module tb_mul_issue;

    // 64 corner ops, 1 wakeup op, 3 chained, 8 fill, 24 random
    localparam int N_DISP = 100;
    localparam int WATCH_CYCLES = N_DISP * (ooo_pkg::RS_DEPTH + ooo_pkg::MUL_STAGES + 20);

    logic                           clk;
    logic                           rst;
    logic                           disp_valid;
    logic [ooo_pkg::TAG_W-1:0]      disp_dst_tag;
    logic [ooo_pkg::TAG_W-1:0]      disp_src1_tag;
    logic [ooo_pkg::TAG_W-1:0]      disp_src2_tag;
    logic                           disp_src1_rdy;
    logic                           disp_src2_rdy;
    logic [rv32m_pkg::FUNCT3_W-1:0] disp_funct3;
    logic                           ext_cdb_valid;
    logic [ooo_pkg::TAG_W-1:0]      ext_cdb_tag;
    logic [rv32m_pkg::XLEN-1:0]     ext_cdb_data;
    logic                           table_full;
    logic                           cdb_valid;
    logic [ooo_pkg::TAG_W-1:0]      cdb_tag;
    logic [rv32m_pkg::XLEN-1:0]     cdb_data;

    // Shadow register file and per-tag scoreboard
    logic [rv32m_pkg::XLEN-1:0] shadow   [ooo_pkg::PRF_DEPTH];
    logic [rv32m_pkg::XLEN-1:0] exp_data [ooo_pkg::PRF_DEPTH];
    logic                       exp_pend [ooo_pkg::PRF_DEPTH];
    int                         pend_count;
    logic [ooo_pkg::TAG_W-1:0]  wait_q [$];

    mul_issue_top i_dut (
        .clk           (clk),
        .rst           (rst),
        .disp_valid    (disp_valid),
        .disp_dst_tag  (disp_dst_tag),
        .disp_src1_tag (disp_src1_tag),
        .disp_src2_tag (disp_src2_tag),
        .disp_src1_rdy (disp_src1_rdy),
        .disp_src2_rdy (disp_src2_rdy),
        .disp_funct3   (disp_funct3),
        .ext_cdb_valid (ext_cdb_valid),
        .ext_cdb_tag   (ext_cdb_tag),
        .ext_cdb_data  (ext_cdb_data),
        .table_full    (table_full),
        .cdb_valid     (cdb_valid),
        .cdb_tag       (cdb_tag),
        .cdb_data      (cdb_data)
    );

    always #2 clk = ~clk;

    task automatic fail_stop(input string why);
        $display("%s", why);
        $display("Regression failed");
        $fatal(1);
    endtask

    `include "tb_mul_checks.svh"

    // rs1 is signed except for MULHU, rs2 only for MUL and MULH
    function automatic logic [rv32m_pkg::XLEN-1:0] ref_mul(
        input logic [rv32m_pkg::FUNCT3_W-1:0] f3,
        input logic [rv32m_pkg::XLEN-1:0]     a,
        input logic [rv32m_pkg::XLEN-1:0]     b
    );
        logic                         a_sgn;
        logic                         b_sgn;
        logic [2*rv32m_pkg::XLEN-1:0] wa;
        logic [2*rv32m_pkg::XLEN-1:0] wb;
        logic [2*rv32m_pkg::XLEN-1:0] prod;
        a_sgn = (f3 != rv32m_pkg::F3_MULHU);
        b_sgn = (f3 == rv32m_pkg::F3_MUL) || (f3 == rv32m_pkg::F3_MULH);
        wa = {{rv32m_pkg::XLEN{a_sgn & a[rv32m_pkg::XLEN-1]}}, a};
        wb = {{rv32m_pkg::XLEN{b_sgn & b[rv32m_pkg::XLEN-1]}}, b};
        prod = wa * wb;
        if (f3 == rv32m_pkg::F3_MUL) begin
            return prod[rv32m_pkg::XLEN-1:0];
        end
        return prod[2*rv32m_pkg::XLEN-1:rv32m_pkg::XLEN];
    endfunction

    // External bus strobe carrying the shadow value of the tag
    task automatic ext_send(input logic [ooo_pkg::TAG_W-1:0] tag);
        @(posedge clk);
        ext_cdb_valid <= 1'b1;
        ext_cdb_tag   <= tag;
        ext_cdb_data  <= shadow[tag];
        @(posedge clk);
        ext_cdb_valid <= 1'b0;
    endtask

    // One dispatch strobe issued only while the station has room
    task automatic dispatch(input logic [ooo_pkg::TAG_W-1:0] dst,
                            input logic [ooo_pkg::TAG_W-1:0] s1, input logic r1,
                            input logic [ooo_pkg::TAG_W-1:0] s2, input logic r2,
                            input logic [rv32m_pkg::FUNCT3_W-1:0] f3);
        logic [rv32m_pkg::XLEN-1:0] res;
        while (exp_pend[dst]) @(posedge clk);
        @(negedge clk);
        while (table_full) @(negedge clk);
        @(posedge clk);
        disp_valid    <= 1'b1;
        disp_dst_tag  <= dst;
        disp_src1_tag <= s1;
        disp_src1_rdy <= r1;
        disp_src2_tag <= s2;
        disp_src2_rdy <= r2;
        disp_funct3   <= f3;
        res = ref_mul(f3, shadow[s1], shadow[s2]);
        exp_data[dst] = res;
        shadow[dst]   = res;
        exp_pend[dst] = 1'b1;
        pend_count++;
        @(posedge clk);
        disp_valid <= 1'b0;
    endtask

    // A full table of waiting ops needs a wakeup before the next dispatch
    task automatic release_while_full();
        @(negedge clk);
        while (table_full && wait_q.size() > 0) begin
            ext_send(wait_q.pop_front());
            @(negedge clk);
        end
    endtask

    task automatic wait_drain();
        while (pend_count > 0) @(posedge clk);
    endtask

    // Every broadcast must match a pending tag
    always @(negedge clk) begin
        if (!rst && cdb_valid) begin
            if (!exp_pend[cdb_tag]) begin
                fail_stop($sformatf("Broadcast of tag %0d that no pending op owns", cdb_tag));
            end
            check_data("cdb_data", cdb_data, exp_data[cdb_tag]);
            exp_pend[cdb_tag] = 1'b0;
            pend_count--;
        end
    end

    initial begin
        repeat (WATCH_CYCLES) @(posedge clk);
        fail_stop($sformatf("Timeout after %0d cycles with %0d results that never arrived",
                            WATCH_CYCLES, pend_count));
    end

    initial begin
        logic [rv32m_pkg::FUNCT3_W-1:0] f3;
        logic                           r1;
        logic                           r2;
        logic [ooo_pkg::TAG_W-1:0]      s1;
        logic [ooo_pkg::TAG_W-1:0]      s2;
        logic [ooo_pkg::TAG_W-1:0]      w;
        clk = 1'b0;
        rst = 1'b1;
        disp_valid = 1'b0;
        disp_dst_tag = '0;
        disp_src1_tag = '0;
        disp_src2_tag = '0;
        disp_src1_rdy = 1'b0;
        disp_src2_rdy = 1'b0;
        disp_funct3 = '0;
        ext_cdb_valid = 1'b0;
        ext_cdb_tag = '0;
        ext_cdb_data = '0;
        pend_count = 0;
        for (int t = 0; t < ooo_pkg::PRF_DEPTH; t++) begin
            shadow[t]   = '0;
            exp_pend[t] = 1'b0;
        end
        repeat (5) @(posedge clk);
        rst <= 1'b0;

        // Idle after reset
        repeat (8) begin
            @(negedge clk);
            check_flag("cdb_valid", cdb_valid, 1'b0);
            check_flag("table_full", table_full, 1'b0);
        end

        // Corner operands where minus one doubles as the all-ones word
        shadow[0] = 32'h0000_0000;
        shadow[1] = 32'hFFFF_FFFF;
        shadow[2] = 32'h8000_0000;
        shadow[3] = 32'h7FFF_FFFF;
        for (int t = 0; t < 4; t++) begin
            ext_send(ooo_pkg::TAG_W'(t));
        end
        for (int f = 0; f < 4; f++) begin
            for (int i = 0; i < 4; i++) begin
                for (int j = 0; j < 4; j++) begin
                    dispatch(ooo_pkg::TAG_W'(32 + (f * 16 + i * 4 + j) % 32),
                             ooo_pkg::TAG_W'(i), 1'b1, ooo_pkg::TAG_W'(j), 1'b1,
                             rv32m_pkg::FUNCT3_W'(f));
                end
            end
        end
        wait_drain();

        // Held until tag 20 shows up on the external bus
        shadow[20] = take_bits(32);
        dispatch(6'd60, 6'd20, 1'b0, 6'd1, 1'b1, rv32m_pkg::F3_MULHSU);
        repeat (10) begin
            @(negedge clk);
            check_flag("cdb_valid", cdb_valid, 1'b0);
        end
        ext_send(6'd20);
        @(negedge clk);
        while (!cdb_valid) @(negedge clk);
        check_tag("cdb_tag", cdb_tag, 6'd60);
        wait_drain();

        // Two-level chain woken by the multiplier's own bus
        dispatch(6'd40, 6'd1, 1'b1, 6'd2, 1'b1, rv32m_pkg::F3_MUL);
        dispatch(6'd41, 6'd40, 1'b0, 6'd3, 1'b1, rv32m_pkg::F3_MULH);
        dispatch(6'd42, 6'd41, 1'b0, 6'd41, 1'b0, rv32m_pkg::F3_MULHU);
        wait_drain();

        // Fill every slot with ops waiting on tags 8 to 15
        for (int t = 0; t < ooo_pkg::RS_DEPTH; t++) begin
            shadow[8 + t] = take_bits(32);
            dispatch(ooo_pkg::TAG_W'(48 + t), ooo_pkg::TAG_W'(8 + t), 1'b0, 6'd3, 1'b1,
                     rv32m_pkg::FUNCT3_W'(t % 4));
        end
        @(negedge clk);
        check_flag("table_full", table_full, 1'b1);
        ext_send(6'd8);
        @(posedge clk);
        @(negedge clk);
        check_flag("table_full", table_full, 1'b0);
        for (int t = 9; t < 16; t++) begin
            ext_send(ooo_pkg::TAG_W'(t));
        end
        wait_drain();

        // Random mix with a ready pool on tags 0 to 7 and one wait tag per op
        for (int t = 0; t < 8; t++) begin
            shadow[t] = take_bits(32);
            ext_send(ooo_pkg::TAG_W'(t));
        end
        for (int k = 0; k < 24; k++) begin
            f3 = rv32m_pkg::FUNCT3_W'(take_bits(2));
            r1 = take_bits(1) != 0;
            r2 = take_bits(1) != 0;
            w  = ooo_pkg::TAG_W'(8 + k);
            shadow[w] = take_bits(32);
            s1 = r1 ? ooo_pkg::TAG_W'(take_bits(3)) : w;
            s2 = r2 ? ooo_pkg::TAG_W'(take_bits(3)) : w;
            release_while_full();
            dispatch(ooo_pkg::TAG_W'(32 + k), s1, r1, s2, r2, f3);
            if (!(r1 && r2)) begin
                wait_q.push_back(w);
            end
            if (take_bits(1) != 0 && wait_q.size() > 0) begin
                ext_send(wait_q.pop_front());
            end
        end
        while (wait_q.size() > 0) begin
            ext_send(wait_q.pop_front());
        end
        wait_drain();

        // Nothing may follow the last expected broadcast
        repeat (ooo_pkg::RS_DEPTH + ooo_pkg::MUL_STAGES) begin
            @(negedge clk);
            check_flag("cdb_valid", cdb_valid, 1'b0);
            check_flag("table_full", table_full, 1'b0);
        end

        $display("Regression passed");
        $finish;
    end

endmodule

`default_nettype wire
